/* fzDecode_cfg.svh */
/*
 * Fz decoder configuration.
 * Widths of the word, register selectors, immediate and commands,
 * and the decode latency.
 */
`ifndef FZ_DECODE_CFG_SVH
`define FZ_DECODE_CFG_SVH

// instruction word in
`define FZ_WORD_W 32

// decoded operation fields
`define FZ_REG_W 6
`define FZ_IMM_W 33
`define FZ_CMD_W 8

`define FZ_PIPE_DEPTH 3

`endif

/* fzDecodePkg.sv */
/*
 * Fz decoder types.
 * Operation and form encodings, register numbers and the
 * structs handed from stage to stage.
 */
`default_nettype none
`include "fzDecode_cfg.svh"

package fzDecodePkg;

	typedef enum logic [5:0] {
		NM_INVOP  = 6'h00,
		NM_MOV_RM = 6'h02,
		NM_MOV_MR = 6'h03,
		NM_LEA_MR = 6'h04,
		NM_BRA    = 6'h08,
		NM_BSR    = 6'h09,
		NM_MOV_IR = 6'h0C,
		NM_ALU3   = 6'h10
	} nmidT;

	// operand forms
	typedef enum logic [4:0] {
		FM_INV        = 5'h00,
		FM_REGREG     = 5'h02,
		FM_REGIMMREG  = 5'h04,
		FM_LDDRREGREG = 5'h06,
		FM_PCDISP     = 5'h08,
		FM_IMM8REG    = 5'h0A,
		FM_IMM12Z     = 5'h0C,
		FM_IMM12N     = 5'h0D
	} fmidT;

	// operand order or immediate extension
	typedef enum logic [3:0] {
		ITY_SB = 4'h0,
		ITY_SW = 4'h1,
		ITY_UW = 4'h5,
		ITY_NB = 4'h8,
		ITY_NW = 4'h9
	} ityT;

	typedef enum logic [2:0] {
		BTY_SB = 3'd0, BTY_SW = 3'd1, BTY_SL = 3'd2, BTY_SQ = 3'd3,
		BTY_UB = 3'd4, BTY_UW = 3'd5, BTY_UL = 3'd6, BTY_UQ = 3'd7
	} btyT;

	typedef enum logic [1:0] {
		CC_AL = 2'd0,
		CC_CT = 2'd2,
		CC_CF = 2'd3
	} cctyT;

	typedef enum logic [5:0] {
		UX_ADD  = 6'h00,
		UX_SUB  = 6'h01,
		UX_AND  = 6'h05,
		UX_OR   = 6'h06,
		UX_XOR  = 6'h07,
		UX_LDIX = 6'h10
	} ucixT;

	typedef logic [`FZ_REG_W-1:0] regIdT;

	// special registers in the top of the selector space
	localparam regIdT GR_ZZR = 6'h3F;
	localparam regIdT GR_IMM = 6'h3E;
	localparam regIdT GR_DLR = 6'h3D;
	localparam regIdT GR_PC  = 6'h3C;
	localparam regIdT GR_GBR = 6'h3B;

	typedef struct packed {
		nmidT nmid;
		fmidT fmid;
		ityT  ity;
		btyT  bty;
		cctyT ccty;
		ucixT ucix;
	} opClassT;

	typedef struct packed {
		regIdT regNDfl;
		regIdT regMDfl;
		regIdT regODfl;
		regIdT regODf2;
		logic  rmIsR0;
		logic  rmIsR1;
	} regFieldsT;

	typedef struct packed {
		regIdT               regN;
		regIdT               regM;
		regIdT               regO;
		logic [`FZ_IMM_W-1:0] imm;
		logic [`FZ_CMD_W-1:0] uCmd;
		logic [`FZ_CMD_W-1:0] uIxt;
	} decodedOpT;

endpackage

`default_nettype wire

/* opClassify.sv */
/*
 * Fz decode stage 1.
 * Matches the word against the F0, F2, F8, FA and FB encodings
 * and registers the operation class with the word.
 */
`timescale 1ns/10ps
`default_nettype none
`include "fzDecode_cfg.svh"

module opClassify import fzDecodePkg::*; (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  inValid,
	input  logic [`FZ_WORD_W-1:0] inWord,
	output logic                  clsValid,
	output logic [`FZ_WORD_W-1:0] clsWord,
	output opClassT               cls
);

	logic [3:0] hiNib;
	logic [3:0] loNib;
	logic [3:0] aluSel;
	logic       exQ;
	opClassT    nextCls;

	function automatic logic isAluSel(input logic [3:0] sel);
		return sel inside {4'h0, 4'h1, 4'h5, 4'h6, 4'h7};
	endfunction

	function automatic ucixT aluOpOf(input logic [3:0] sel);
		case (sel)
			4'h1: return UX_SUB;
			4'h5: return UX_AND;
			4'h6: return UX_OR;
			4'h7: return UX_XOR;
			default: return UX_ADD;
		endcase
	endfunction

	assign hiNib = inWord[31:28];
	assign loNib = inWord[19:16];
	assign exQ   = inWord[27];
	// NB order takes its op from the Ro nibble
	assign aluSel = (loNib == 4'h9) ? inWord[23:20] : loNib;

	always_comb begin
		nextCls = '{nmid: NM_INVOP, fmid: FM_INV, ity: ITY_SB,
			bty: BTY_SB, ccty: CC_AL, ucix: UX_ADD};
		if (inWord[15:13] == 3'b111) begin
			casez (inWord[11:8])
				4'b0z00: begin
					if (hiNib == 4'h0 && loNib[3:2] == 2'b01) begin
						// Q turns a store into an address load
						nextCls.nmid = exQ ? NM_LEA_MR : NM_MOV_RM;
						nextCls.fmid = FM_LDDRREGREG;
						nextCls.bty  = btyT'({1'b0, loNib[1:0]});
					end else if (hiNib == 4'h0 && loNib[3:2] == 2'b11) begin
						nextCls.nmid = NM_MOV_MR;
						nextCls.fmid = FM_LDDRREGREG;
						if (!exQ)
							nextCls.bty = btyT'({1'b0, loNib[1:0]});
						else if (loNib == 4'hF)
							nextCls.bty = BTY_SL;
						else
							nextCls.bty = btyT'({1'b1, loNib[1:0]});
					end else if (hiNib == 4'h1 && isAluSel(aluSel)) begin
						nextCls.nmid = NM_ALU3;
						nextCls.fmid = FM_REGREG;
						nextCls.ity  = (loNib == 4'h9) ? ITY_NB : ITY_SB;
						nextCls.ucix = aluOpOf(aluSel);
					end else if (hiNib[3:2] == 2'b11) begin
						// 20-bit PC-relative branches
						nextCls.nmid = (hiNib == 4'hD) ? NM_BSR : NM_BRA;
						nextCls.fmid = FM_PCDISP;
						nextCls.ity  = ITY_SW;
						nextCls.bty  = BTY_SW;
						if (hiNib == 4'hE)
							nextCls.ccty = CC_CT;
						else if (hiNib == 4'hF)
							nextCls.ccty = CC_CF;
					end
				end
				4'b0z10: begin
					if (isAluSel(hiNib)) begin
						nextCls.nmid = NM_ALU3;
						nextCls.fmid = FM_REGIMMREG;
						nextCls.ity  = (hiNib == 4'h1) ? ITY_NW : ITY_UW;
						nextCls.ucix = (hiNib == 4'h1) ? UX_ADD : aluOpOf(hiNib);
					end
				end
				4'b100z: begin
					case (inWord[7:5])
						3'b000, 3'b001: begin
							nextCls.nmid = NM_MOV_IR;
							nextCls.fmid = FM_IMM8REG;
							nextCls.ity  = inWord[5] ? ITY_NW : ITY_UW;
							nextCls.ucix = UX_LDIX;
						end
						3'b010: begin
							nextCls.nmid = NM_ALU3;
							nextCls.fmid = FM_IMM8REG;
							nextCls.ucix = UX_ADD;
						end
						default: ;
					endcase
				end
				4'b101z: begin
					nextCls.nmid = NM_MOV_IR;
					nextCls.fmid = inWord[8] ? FM_IMM12N : FM_IMM12Z;
					nextCls.ucix = UX_LDIX;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			clsValid <= 1'b0;
		else
			clsValid <= inValid;
	end

	always_ff @(posedge clock) begin
		clsWord <= inWord;
		cls     <= nextCls;
	end

	clsValidKnown: assert property (@(posedge clock) disable iff (!arstN)
		!$isunknown(clsValid));

endmodule

`default_nettype wire

/* fieldExtract.sv */
/*
 * Fz decode stage 2.
 * Builds the default register selectors and the R0/R1 base
 * flags from the word, carrying the class along.
 */
`timescale 1ns/10ps
`default_nettype none
`include "fzDecode_cfg.svh"

module fieldExtract import fzDecodePkg::*; (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  clsValid,
	input  logic [`FZ_WORD_W-1:0] clsWord,
	input  opClassT               cls,
	output logic                  fldValid,
	output logic [`FZ_WORD_W-1:0] fldWord,
	output opClassT               fldCls,
	output regFieldsT             fld
);

	regFieldsT nextFld;

	// low nibbles of 0/1 and 15 map into the special space unless extended
	function automatic regIdT dflReg(input logic [3:0] nib, input logic ext);
		logic special;
		special = (nib[3:1] == 3'b000) || (nib == 4'hF);
		return {special & ~ext, ext, nib};
	endfunction

	always_comb begin
		nextFld.regNDfl = dflReg(clsWord[7:4], clsWord[26]);
		nextFld.regMDfl = dflReg(clsWord[3:0], clsWord[25]);
		nextFld.regODfl = dflReg(clsWord[23:20], clsWord[24]);
		nextFld.regODf2 = dflReg(clsWord[3:0], clsWord[4]);
		nextFld.rmIsR0  = (nextFld.regMDfl[4:1] == 4'b0000) && !nextFld.regMDfl[0];
		nextFld.rmIsR1  = (nextFld.regMDfl[4:1] == 4'b0000) && nextFld.regMDfl[0];
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			fldValid <= 1'b0;
		else
			fldValid <= clsValid;
	end

	always_ff @(posedge clock) begin
		fldWord <= clsWord;
		fldCls  <= cls;
		fld     <= nextFld;
	end

endmodule

`default_nettype wire

/* operandSelect.sv */
/*
 * Fz decode stage 3.
 * Picks registers and builds the immediate per operand form,
 * then forms the micro-command and extended command.
 */
`timescale 1ns/10ps
`default_nettype none
`include "fzDecode_cfg.svh"

module operandSelect import fzDecodePkg::*; (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  fldValid,
	input  logic [`FZ_WORD_W-1:0] fldWord,
	input  opClassT               fldCls,
	input  regFieldsT             fld,
	output logic                  outValid,
	output decodedOpT             outOp
);

	decodedOpT nextOp;

	always_comb begin
		nextOp.regN = GR_ZZR;
		nextOp.regM = GR_ZZR;
		nextOp.regO = GR_ZZR;
		nextOp.imm  = '0;
		nextOp.uCmd = {fldCls.ccty, fldCls.nmid};
		nextOp.uIxt = {fldCls.ccty, fldCls.ucix};
		case (fldCls.fmid)
			FM_REGREG: begin
				nextOp.regN = fld.regNDfl;
				if (fldCls.ity == ITY_NB) begin
					nextOp.regM = fld.regNDfl;
					nextOp.regO = fld.regMDfl;
				end else begin
					nextOp.regM = fld.regMDfl;
					nextOp.regO = fld.regODfl;
				end
				nextOp.imm = {28'h0, fldWord[4:0]};
			end
			FM_REGIMMREG: begin
				nextOp.regN = fld.regNDfl;
				nextOp.regM = fld.regMDfl;
				nextOp.regO = GR_IMM;
				nextOp.imm  = {{24{fldCls.ity == ITY_NW}}, fldWord[24:16]};
			end
			FM_LDDRREGREG: begin
				nextOp.regN = fld.regNDfl;
				nextOp.regM = fld.regMDfl;
				nextOp.regO = fld.regODfl;
				nextOp.uIxt = {fldCls.ccty, fldCls.bty[1:0], 1'b1, fldCls.bty};
				// R0 and R1 as base mean PC and GBR
				if (fld.rmIsR0 || fld.rmIsR1) begin
					nextOp.regM = fld.rmIsR1 ? GR_GBR : GR_PC;
					nextOp.uIxt = {fldCls.ccty, fldCls.bty[1:0], 1'b1,
						fldCls.bty[2], 2'b00};
				end
			end
			FM_PCDISP: begin
				nextOp.regN = GR_DLR;
				nextOp.regM = GR_PC;
				nextOp.regO = GR_IMM;
				nextOp.imm  = {{13{fldWord[7]}}, fldWord[7:0], fldWord[27:16]};
				nextOp.uIxt = {fldCls.ccty, fldCls.bty[1:0], 1'b1, fldCls.bty};
			end
			FM_IMM8REG: begin
				if (fldCls.ity == ITY_SB) begin
					nextOp.regN = fld.regODf2;
					nextOp.regM = fld.regODf2;
					nextOp.regO = GR_IMM;
					nextOp.imm  = {{17{fldWord[31]}}, fldWord[31:16]};
				end else begin
					nextOp.regN = fld.regODf2;
					nextOp.regM = GR_IMM;
					nextOp.regO = fld.regODf2;
					nextOp.imm  = {{17{fldCls.ity == ITY_NW}}, fldWord[31:16]};
				end
			end
			FM_IMM12Z, FM_IMM12N: begin
				nextOp.regN = GR_DLR;
				nextOp.regM = GR_DLR;
				nextOp.regO = GR_IMM;
				nextOp.imm  = {{9{fldCls.fmid == FM_IMM12N}}, fldWord[7:0], fldWord[31:16]};
			end
			default: begin
				nextOp.uCmd = {CC_AL, NM_INVOP};
				nextOp.uIxt = '0;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			outValid <= 1'b0;
		else
			outValid <= fldValid;
	end

	always_ff @(posedge clock) begin
		outOp <= nextOp;
	end

	// a decoded op always carries a real operand form
	formKept: assert property (@(posedge clock) disable iff (!arstN)
		fldValid && fldCls.nmid != NM_INVOP |-> fldCls.fmid inside {FM_REGREG,
			FM_REGIMMREG, FM_LDDRREGREG, FM_PCDISP, FM_IMM8REG, FM_IMM12Z, FM_IMM12N});

endmodule

`default_nettype wire

/* fzDecoder.sv */
/*
 * Fz instruction decoder, three-stage pipeline.
 * One word in per cycle, decoded operation out three cycles later.
 */
`timescale 1ns/10ps
`default_nettype none
`include "fzDecode_cfg.svh"

module fzDecoder import fzDecodePkg::*; (
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  inValid,
	input  logic [`FZ_WORD_W-1:0] inWord,
	output logic                  outValid,
	output decodedOpT             outOp
);

	logic                  clsValid;
	logic [`FZ_WORD_W-1:0] clsWord;
	opClassT               cls;
	logic                  fldValid;
	logic [`FZ_WORD_W-1:0] fldWord;
	opClassT               fldCls;
	regFieldsT             fld;

	opClassify uClassify (
		.clock(clock),
		.arstN(arstN),
		.inValid(inValid),
		.inWord(inWord),
		.clsValid(clsValid),
		.clsWord(clsWord),
		.cls(cls)
	);

	fieldExtract uFields (
		.clock(clock),
		.arstN(arstN),
		.clsValid(clsValid),
		.clsWord(clsWord),
		.cls(cls),
		.fldValid(fldValid),
		.fldWord(fldWord),
		.fldCls(fldCls),
		.fld(fld)
	);

	operandSelect uSelect (
		.clock(clock),
		.arstN(arstN),
		.fldValid(fldValid),
		.fldWord(fldWord),
		.fldCls(fldCls),
		.fld(fld),
		.outValid(outValid),
		.outOp(outOp)
	);

endmodule

`default_nettype wire

/* fzDecoderModel.svh */
/*
 * Reference decode for the Fz decoder testbench.
 * Gives the decoded operation that one word should produce.
 */
`ifndef FZ_DECODER_MODEL_SVH
`define FZ_DECODER_MODEL_SVH

// R0, R1 and R15 land in the special space unless extended
function automatic regIdT expField(input logic [3:0] nib, input logic ext);
	logic low;
	low = (nib <= 4'h1) || (nib == 4'hF);
	return {low && !ext, ext, nib};
endfunction

// all ones when the selector is not a kept ALU op
function automatic logic [5:0] aluCode(input logic [3:0] sel);
	case (sel)
		4'h0: return UX_ADD;
		4'h1: return UX_SUB;
		4'h5: return UX_AND;
		4'h6: return UX_OR;
		4'h7: return UX_XOR;
		default: return 6'h3F;
	endcase
endfunction

function automatic decodedOpT expectOp(input logic [31:0] w);
	decodedOpT  op;
	logic [3:0] h;
	logic [3:0] l;
	logic [3:0] grp;
	logic [3:0] sel;
	logic [2:0] bt;
	logic [1:0] cc;
	logic       f0;
	logic       base;
	regIdT      rn;
	regIdT      rm;
	regIdT      r2;
	op = '{regN: GR_ZZR, regM: GR_ZZR, regO: GR_ZZR, imm: '0, uCmd: '0, uIxt: '0};
	h = w[31:28];
	l = w[19:16];
	grp = w[11:8];
	f0 = (grp == 4'h0) || (grp == 4'h4);
	sel = (l == 4'h9) ? w[23:20] : l;
	rn = expField(w[7:4], w[26]);
	rm = expField(w[3:0], w[25]);
	r2 = expField(w[3:0], w[4]);
	base = !w[25] && (w[3:1] == 3'b000);
	if (w[15:13] != 3'b111) begin
		// non-Fx words stay invalid
	end else if (f0 && h == 4'h0 && l[2]) begin
		bt = {1'b0, l[1:0]};
		if (l[3] && w[27])
			bt = (l == 4'hF) ? 3'd2 : {1'b1, l[1:0]};
		op.uCmd = {CC_AL, l[3] ? NM_MOV_MR : (w[27] ? NM_LEA_MR : NM_MOV_RM)};
		op.regN = rn;
		op.regM = !base ? rm : (w[0] ? GR_GBR : GR_PC);
		op.regO = expField(w[23:20], w[24]);
		op.uIxt = {CC_AL, bt[1:0], 1'b1, base ? {bt[2], 2'b00} : bt};
	end else if (f0 && h == 4'h1 && aluCode(sel) != 6'h3F) begin
		op.uCmd = {CC_AL, NM_ALU3};
		op.uIxt = {CC_AL, aluCode(sel)};
		op.regN = rn;
		op.regM = (l == 4'h9) ? rn : rm;
		op.regO = (l == 4'h9) ? rm : expField(w[23:20], w[24]);
		op.imm  = {28'd0, w[4:0]};
	end else if (f0 && h[3:2] == 2'b11) begin
		cc = (h == 4'hE) ? CC_CT : ((h == 4'hF) ? CC_CF : CC_AL);
		op.uCmd = {cc, (h == 4'hD) ? NM_BSR : NM_BRA};
		// word-sized displacement
		op.uIxt = {cc, 2'b01, 1'b1, 3'b001};
		op.regN = GR_DLR;
		op.regM = GR_PC;
		op.regO = GR_IMM;
		op.imm  = {{13{w[7]}}, w[7:0], w[27:16]};
	end else if ((grp == 4'h2 || grp == 4'h6) && aluCode(h) != 6'h3F) begin
		op.uCmd = {CC_AL, NM_ALU3};
		op.uIxt = {CC_AL, aluCode((h == 4'h1) ? 4'h0 : h)};
		op.regN = rn;
		op.regM = rm;
		op.regO = GR_IMM;
		op.imm  = {{24{h == 4'h1}}, w[24:16]};
	end else if ((grp == 4'h8 || grp == 4'h9) && w[7:5] <= 3'b010) begin
		op.uCmd = {CC_AL, w[6] ? NM_ALU3 : NM_MOV_IR};
		op.uIxt = {CC_AL, w[6] ? UX_ADD : UX_LDIX};
		op.regN = r2;
		op.regM = w[6] ? r2 : GR_IMM;
		op.regO = w[6] ? GR_IMM : r2;
		op.imm  = {{17{w[6] ? w[31] : w[5]}}, w[31:16]};
	end else if (grp == 4'hA || grp == 4'hB) begin
		op.uCmd = {CC_AL, NM_MOV_IR};
		op.uIxt = {CC_AL, UX_LDIX};
		op.regN = GR_DLR;
		op.regM = GR_DLR;
		op.regO = GR_IMM;
		op.imm  = {{9{grp[0]}}, w[7:0], w[31:16]};
	end
	return op;
endfunction

`endif

/* fzDecoderTb.sv */
/*
 * Fz decoder testbench.
 * Directed words for each kept encoding, then LCG words with
 * random gaps, checked by assertions against a latency queue.
 */
`timescale 1ns/10ps
`default_nettype none
`include "fzDecode_cfg.svh"

module fzDecoderTb import fzDecodePkg::*; ();

	`include "fzDecoderModel.svh"

	localparam int nDirected = 40;
	localparam int nRandom   = 300;
	localparam int maxCycles = 2 * (nDirected + nRandom) + `FZ_PIPE_DEPTH + 20;

	// hex digits read h x o l F g n m
	localparam logic [31:0] directedWords [nDirected] = '{
		32'h0034_F025, 32'h0835_F020, 32'h0036_F421, 32'h0037_F027,
		32'h001C_F0F9, 32'h081D_F011, 32'h082E_F034, 32'h082F_F034,
		32'h020C_F030, 32'h1050_F034, 32'h17F1_F401, 32'h1025_F033,
		32'h1026_F03F, 32'h1027_F013, 32'h1019_F034, 32'h1479_F4FE,
		32'h1009_F00A, 32'h0155_F234, 32'h11FF_F601, 32'h5000_F222,
		32'h60AB_F2C7, 32'h7123_F245, 32'hC5AB_F083, 32'hD207_F071,
		32'hE3FF_F4F0, 32'hF000_F012, 32'h8012_F805, 32'hFFFF_F930,
		32'h9234_F84F, 32'h0123_F850, 32'h1234_FAFF, 32'h0000_FB81,
		32'h0000_0000, 32'h0008_F000, 32'h1039_F000, 32'h2000_F000,
		32'h8000_F200, 32'h0000_F860, 32'h1000_F100, 32'h1000_D000
	};
	localparam logic [3:0] groupCodes [8] = '{4'h0, 4'h4, 4'h2, 4'h6, 4'h8, 4'h9, 4'hA, 4'hB};

	logic                  clock;
	logic                  arstN;
	logic                  inValid;
	logic [`FZ_WORD_W-1:0] inWord;
	logic                  outValid;
	decodedOpT             outOp;

	decodedOpT   expQ[$];
	decodedOpT   expHead;
	logic        haveExp;
	logic [31:0] lcgState;
	int          valueErrs = 0;
	int          otherErrs = 0;
	int          cycles = 0;

	fzDecoder u_dut (
		.clock(clock),
		.arstN(arstN),
		.inValid(inValid),
		.inWord(inWord),
		.outValid(outValid),
		.outOp(outOp)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic refreshHead();
		haveExp = (expQ.size() > 0);
		if (haveExp)
			expHead = expQ[0];
	endtask

	task automatic valueError(input string field);
		valueErrs++;
		$display("** Error at %0t: %s does not match the expected value", $time, field);
	endtask

	task automatic otherError(input string what);
		otherErrs++;
		$display("at %0t: %s", $time, what);
	endtask

	task automatic sendWord(input logic [31:0] w, input logic v);
		@(negedge clock);
		inWord  = w;
		inValid = v;
		if (v) begin
			expQ.push_back(expectOp(w));
			refreshHead();
		end
	endtask

	task automatic sendRandom();
		logic [31:0] word;
		logic [31:0] ctl;
		lcgState = lcgNext(lcgState);
		word = lcgState;
		lcgState = lcgNext(lcgState);
		ctl = lcgState;
		// mostly Fx words in a kept group
		if (ctl[31:29] != 3'd0)
			word[15:8] = {4'hF, groupCodes[ctl[28:26]]};
		sendWord(word, ctl[25:24] != 2'd0);
	endtask

	// retire outputs and stop a run that never drains
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (outValid && expQ.size() > 0) begin
			void'(expQ.pop_front());
			refreshHead();
		end
		if (cycles >= maxCycles) begin
			$display("timeout: the run did not finish within %0d cycles", maxCycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	resetQuiet: assert property (@(posedge clock) !arstN |-> !outValid)
		else otherError("outValid was high during reset");
	validFollows: assert property (@(posedge clock) disable iff (!arstN)
		inValid |-> ##`FZ_PIPE_DEPTH outValid)
		else otherError("an accepted word did not come out after the pipeline latency");
	gapFollows: assert property (@(posedge clock) disable iff (!arstN)
		!inValid |-> ##`FZ_PIPE_DEPTH !outValid)
		else otherError("outValid rose without a matching input word");
	headPresent: assert property (@(posedge clock) disable iff (!arstN)
		outValid |-> haveExp)
		else otherError("an output arrived with no word in flight");

	regNMatch: assert property (@(posedge clock) disable iff (!arstN)
		outValid && haveExp |-> outOp.regN == expHead.regN) else valueError("regN");
	regMMatch: assert property (@(posedge clock) disable iff (!arstN)
		outValid && haveExp |-> outOp.regM == expHead.regM) else valueError("regM");
	regOMatch: assert property (@(posedge clock) disable iff (!arstN)
		outValid && haveExp |-> outOp.regO == expHead.regO) else valueError("regO");
	immMatch: assert property (@(posedge clock) disable iff (!arstN)
		outValid && haveExp |-> outOp.imm == expHead.imm) else valueError("imm");
	uCmdMatch: assert property (@(posedge clock) disable iff (!arstN)
		outValid && haveExp |-> outOp.uCmd == expHead.uCmd) else valueError("uCmd");
	uIxtMatch: assert property (@(posedge clock) disable iff (!arstN)
		outValid && haveExp |-> outOp.uIxt == expHead.uIxt) else valueError("uIxt");

	initial begin
		inValid  = 1'b0;
		inWord   = '0;
		arstN    = 1'b0;
		haveExp  = 1'b0;
		expHead  = '0;
		lcgState = 32'd29;
		repeat (5) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		for (int i = 0; i < nDirected; i++)
			sendWord(directedWords[i], 1'b1);
		for (int i = 0; i < nRandom; i++)
			sendRandom();
		sendWord('0, 1'b0);
		wait (!haveExp);
		// let the trailing gaps reach the output
		repeat (`FZ_PIPE_DEPTH + 1) @(negedge clock);
		$display("errors: %0d wrong values, %0d other", valueErrs, otherErrs);
		if (valueErrs + otherErrs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
fzDecodePkg.sv
opClassify.sv
fieldExtract.sv
operandSelect.sv
fzDecoder.sv
fzDecoderTb.sv
